//--- src/alu_macros.svh
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// Operand word and its exponent/mantissa split.
`define ALU_WORD_W 48
`define ALU_EXP_W 7
`define ALU_MANT_W 41

// Width of the ones count and the leading-zero count.
`define ALU_CNT_W 6

// Number of mask bits walked by the unpack loop.
`define ALU_UNPACK_STEPS 48

// Exponent field value that means a shift by zero.
`define ALU_SHIFT_BIAS 64

`endif

//--- src/alu_word_pkg.sv
`default_nettype none

`include "alu_macros.svh"

package alu_word_pkg;

    // Exponent field over the mantissa, as the floating-point format lays it out.
    typedef struct packed {
        logic [`ALU_EXP_W-1:0]  exp;
        logic [`ALU_MANT_W-1:0] mant;
    } alu_float_t;

    // One operand word.
    // The shift reads the exponent field as a biased count, everything else the raw bits.
    typedef union packed {
        logic [`ALU_WORD_W-1:0] raw;
        alu_float_t             fp;
    } alu_word_u;

    // Sequencer states of the execute block.
    typedef enum logic [2:0] {
        IDLE         = 3'd0,
        ADD_B        = 3'd1,
        ADD_CARRY    = 3'd2,
        SHIFTING     = 3'd3,
        PACKING      = 3'd4,
        UNPACKING    = 3'd5
    } alu_state_e;

endpackage

`default_nettype wire

//--- src/alu_op_pkg.sv
`default_nettype none

`include "alu_macros.svh"

package alu_op_pkg;

    import alu_word_pkg::*;

    // Operation codes as held by the control sequencer.
    typedef enum logic [3:0] {
        NOP    = 4'd0,
        YTA    = 4'd1,
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        ARX    = 4'd5,
        ACX    = 4'd6,
        ANX    = 4'd7,
        SHIFT  = 4'd8,
        PACK   = 4'd9,
        UNPACK = 4'd10
    } alu_op_e;

    // Register loads applied on the first cycle of an operation.
    typedef struct packed {
        logic [`ALU_WORD_W-1:0] acc;
        logic [`ALU_WORD_W-1:0] y;
        logic                   carry;
        logic [`ALU_WORD_W-1:0] rail;
        logic [`ALU_EXP_W-1:0]  cnt;
        alu_state_e             state;
        logic                   done;
    } alu_start_t;

endpackage

`default_nettype wire

//--- src/alu_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_macros.svh"

module alu_decode
    import alu_op_pkg::*, alu_word_pkg::*;
(
    input  wire alu_op_e                op,
    input  wire alu_word_u              a,
    input  wire alu_word_u              b,
    input  wire logic [`ALU_WORD_W-1:0] y,
    output alu_start_t                  start
);

    logic [`ALU_CNT_W-1:0]  ones_cnt;
    logic [`ALU_CNT_W-1:0]  lz_cnt;
    logic [`ALU_WORD_W:0]   sum;

    // Number of ones in A.
    always_comb begin
        ones_cnt = '0;
        for (int i = 0; i < `ALU_WORD_W; i++) begin
            ones_cnt = ones_cnt + `ALU_CNT_W'(a.raw[i]);
        end
    end

    // Leading zeros plus one; the highest set bit wins, zero when A is zero.
    always_comb begin
        lz_cnt = '0;
        for (int i = 0; i < `ALU_WORD_W; i++) begin
            if (a.raw[i]) begin
                lz_cnt = `ALU_CNT_W'(`ALU_WORD_W - i);
            end
        end
    end

    assign sum = {1'b0, a.raw} + {1'b0, b.raw};

    always_comb begin
        start.acc   = '0;
        start.y     = y;
        start.carry = 1'b0;
        start.rail  = '0;
        start.cnt   = '0;
        start.state = IDLE;
        start.done  = 1'b0;
        case (op)
            YTA: begin
                start.acc  = y;
                start.done = 1'b1;
            end
            AND: begin
                start.acc  = a.raw & b.raw;
                start.y    = '0;
                start.done = 1'b1;
            end
            OR: begin
                start.acc  = a.raw | b.raw;
                start.y    = '0;
                start.done = 1'b1;
            end
            XOR: begin
                start.acc  = a.raw ^ b.raw;
                start.y    = a.raw;
                start.done = 1'b1;
            end
            ARX: begin
                {start.carry, start.acc} = sum;
                start.y     = '0;
                start.state = ADD_CARRY;
            end
            ACX: begin
                start.acc   = {{(`ALU_WORD_W-`ALU_CNT_W){1'b0}}, ones_cnt};
                start.y     = '0;
                start.state = ADD_B;
            end
            ANX: begin
                start.acc   = {{(`ALU_WORD_W-`ALU_CNT_W){1'b0}}, lz_cnt};
                start.y     = a.raw << lz_cnt;
                start.state = ADD_B;
            end
            SHIFT: begin
                // A zero shift count finishes at once.
                start.acc = a.raw;
                start.y   = '0;
                start.cnt = b.fp.exp;
                if (b.fp.exp == `ALU_EXP_W'(`ALU_SHIFT_BIAS)) begin
                    start.done = 1'b1;
                end else begin
                    start.state = SHIFTING;
                end
            end
            PACK: begin
                start.rail = a.raw;
                start.y    = b.raw;
                if (b.raw == '0) begin
                    start.done = 1'b1;
                end else begin
                    start.state = PACKING;
                end
            end
            UNPACK: begin
                start.rail  = a.raw;
                start.y     = b.raw;
                start.cnt   = `ALU_EXP_W'(`ALU_UNPACK_STEPS);
                start.state = UNPACKING;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/alu_shift_step.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_macros.svh"

module alu_shift_step (
    input  wire logic [`ALU_WORD_W-1:0] acc,
    input  wire logic [`ALU_WORD_W-1:0] y,
    input  wire logic [`ALU_EXP_W-1:0]  count,
    output logic [`ALU_WORD_W-1:0]      acc_next,
    output logic [`ALU_WORD_W-1:0]      y_next,
    output logic [`ALU_EXP_W-1:0]       count_next
);

    logic [2:0] right_amt;
    logic [2:0] left_amt;
    logic       go_right;
    logic       go_left;

    // The first step brings the count to a multiple of four, later steps move by four.
    assign right_amt = (count[1:0] == 2'b00) ? 3'd4 : {1'b0, count[1:0]};
    assign left_amt  = 3'd4 - {1'b0, count[1:0]};

    assign go_right = count > `ALU_EXP_W'(`ALU_SHIFT_BIAS);
    assign go_left  = count < `ALU_EXP_W'(`ALU_SHIFT_BIAS);

    always_comb begin
        acc_next   = acc;
        y_next     = y;
        count_next = count;
        if (go_right) begin
            // Bits leaving acc drop into the top of Y.
            {acc_next, y_next} = {acc, y} >> right_amt;
            count_next = count - {{(`ALU_EXP_W-3){1'b0}}, right_amt};
        end else if (go_left) begin
            // Bits leaving acc rise into the bottom of Y.
            {y_next, acc_next} = {y, acc} << left_amt;
            count_next = count + {{(`ALU_EXP_W-3){1'b0}}, left_amt};
        end
    end

endmodule

`default_nettype wire

//--- src/alu_execute.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_macros.svh"

module alu_execute
    import alu_op_pkg::*, alu_word_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire alu_op_e                op,
    input  wire logic                   wy,
    input  wire alu_word_u              a,
    input  wire alu_word_u              b,
    input  wire alu_start_t             start,
    input  wire logic [`ALU_WORD_W-1:0] acc_next,
    input  wire logic [`ALU_WORD_W-1:0] y_next,
    input  wire logic [`ALU_EXP_W-1:0]  count_next,
    output logic [`ALU_WORD_W-1:0]      acc,
    output logic [`ALU_WORD_W-1:0]      y,
    output logic [`ALU_EXP_W-1:0]       count,
    output logic                        done
);

    alu_state_e             state;
    logic                   carry;
    logic [`ALU_WORD_W-1:0] rail;
    logic [`ALU_WORD_W:0]   a_mux;
    logic [`ALU_WORD_W:0]   b_mux;
    logic [`ALU_WORD_W:0]   sum;

    // Adder: acc plus B, or acc plus the latched carry for the end-around pass.
    assign a_mux = {1'b0, acc};
    assign b_mux = (state == ADD_CARRY) ? {{`ALU_WORD_W{1'b0}}, carry} : {1'b0, b.raw};
    assign sum   = a_mux + b_mux;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            done  <= 1'b0;
            acc   <= '0;
            y     <= '0;
            carry <= 1'b0;
            rail  <= '0;
            count <= '0;
        end else if (op == NOP) begin
            state <= IDLE;
            done  <= 1'b0;
            if (wy) begin
                y <= a.raw;
            end
        end else if (!done) begin
            case (state)
                IDLE: begin
                    acc   <= start.acc;
                    y     <= start.y;
                    carry <= start.carry;
                    rail  <= start.rail;
                    count <= start.cnt;
                    state <= start.state;
                    done  <= start.done;
                end
                ADD_B: begin
                    {carry, acc} <= sum;
                    state <= ADD_CARRY;
                end
                ADD_CARRY: begin
                    acc  <= sum[`ALU_WORD_W-1:0];
                    done <= 1'b1;
                end
                SHIFTING: begin
                    acc   <= acc_next;
                    y     <= y_next;
                    count <= count_next;
                    if (count_next == `ALU_EXP_W'(`ALU_SHIFT_BIAS)) begin
                        done <= 1'b1;
                    end
                end
                PACKING: begin
                    // Y walks the mask from the bottom; a picked rail bit enters acc at the top.
                    if (y[0]) begin
                        acc <= {rail[0], acc[`ALU_WORD_W-1:1]};
                    end
                    y    <= y >> 1;
                    rail <= rail >> 1;
                    if (y[`ALU_WORD_W-1:1] == '0) begin
                        done <= 1'b1;
                    end
                end
                UNPACKING: begin
                    // Every mask bit shifts acc once, rail moves only on a set bit.
                    acc <= {rail[0] & y[0], acc[`ALU_WORD_W-1:1]};
                    y   <= y >> 1;
                    if (y[0]) begin
                        rail <= rail >> 1;
                    end
                    count <= count - 1'b1;
                    if (count == `ALU_EXP_W'(1)) begin
                        done <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Done only follows an edge that sampled a real operation.
    done_needs_op: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(done) |-> ($past(op) != NOP)
    ) else $error("done rose after a NOP cycle");

    // The sequencer holds the operation code until it returns to NOP.
    op_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state != IDLE && op != NOP) |=> (op == NOP || $stable(op))
    ) else $error("op changed while an operation was running");

endmodule

`default_nettype wire

//--- src/mesm_alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_macros.svh"

module mesm_alu
    import alu_op_pkg::*, alu_word_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire alu_op_e           op,
    input  wire logic              wy,
    input  wire alu_word_u         a,
    input  wire alu_word_u         b,
    output logic [`ALU_WORD_W-1:0] acc,
    output logic                   done
);

    alu_start_t             start;
    logic [`ALU_WORD_W-1:0] y;
    logic [`ALU_EXP_W-1:0]  count;
    logic [`ALU_WORD_W-1:0] acc_next;
    logic [`ALU_WORD_W-1:0] y_next;
    logic [`ALU_EXP_W-1:0]  count_next;

    alu_decode u_decode (
        .op    (op),
        .a     (a),
        .b     (b),
        .y     (y),
        .start (start)
    );

    alu_shift_step u_shift_step (
        .acc        (acc),
        .y          (y),
        .count      (count),
        .acc_next   (acc_next),
        .y_next     (y_next),
        .count_next (count_next)
    );

    alu_execute u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .op         (op),
        .wy         (wy),
        .a          (a),
        .b          (b),
        .start      (start),
        .acc_next   (acc_next),
        .y_next     (y_next),
        .count_next (count_next),
        .acc        (acc),
        .y          (y),
        .count      (count),
        .done       (done)
    );

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release reset just after an edge, like the other inputs.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- dv/alu_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_macros.svh"

module alu_checker #(
    parameter int NAME_W = 8 * 24
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   done,
    input  wire logic [`ALU_WORD_W-1:0] acc,
    input  wire logic [`ALU_WORD_W-1:0] exp_acc,
    input  wire logic [NAME_W-1:0]      case_name,
    output int                          check_count,
    output int                          mismatch_count
);

    logic done_q;

    // The edge after done rises still sees the finished acc, since NOP leaves it alone.
    always @(posedge clk) begin
        if (!rst_n) begin
            done_q         <= 1'b0;
            check_count    <= 0;
            mismatch_count <= 0;
        end else begin
            done_q <= done;
            if (done && !done_q) begin
                check_count <= check_count + 1;
                if (acc !== exp_acc) begin
                    $display("Error %0s: expected %012h, actual %012h",
                             case_name, exp_acc, acc);
                    mismatch_count <= mismatch_count + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_mesm_alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_macros.svh"

module tb_mesm_alu
    import alu_op_pkg::*, alu_word_pkg::*;
();

    localparam int NAME_W        = 8 * 24;
    localparam int LINE_W        = 8 * 160;
    localparam int DONE_TIMEOUT  = 200;
    localparam int RESET_TIMEOUT = 50;

    localparam logic [`ALU_WORD_W-1:0] Y_FILL = 48'h5A5A_C3C3_0F0F;

    logic                   clk;
    logic                   rst_n;
    alu_op_e                op;
    logic                   wy;
    alu_word_u              a;
    alu_word_u              b;
    logic [`ALU_WORD_W-1:0] acc;
    logic                   done;
    logic [`ALU_WORD_W-1:0] exp_acc;
    logic [NAME_W-1:0]      case_name;
    int                     check_count;
    int                     mismatch_count;
    int                     cases_done;
    int                     timeout_count;
    int                     other_errors;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mesm_alu DUT (
        .clk   (clk),
        .rst_n (rst_n),
        .op    (op),
        .wy    (wy),
        .a     (a),
        .b     (b),
        .acc   (acc),
        .done  (done)
    );

    alu_checker #(.NAME_W(NAME_W)) u_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .done           (done),
        .acc            (acc),
        .exp_acc        (exp_acc),
        .case_name      (case_name),
        .check_count    (check_count),
        .mismatch_count (mismatch_count)
    );

    task automatic drive_nop(input logic wy_val, input logic [`ALU_WORD_W-1:0] a_val);
        op    = NOP;
        wy    = wy_val;
        a.raw = a_val;
        b.raw = '0;
    endtask

    task automatic op_from_name(input logic [63:0] txt, output alu_op_e code,
                                output logic known);
        known = 1'b1;
        code  = NOP;
        case (txt)
            "YTA":    code = YTA;
            "AND":    code = AND;
            "OR":     code = OR;
            "XOR":    code = XOR;
            "ARX":    code = ARX;
            "ACX":    code = ACX;
            "ANX":    code = ANX;
            "SHIFT":  code = SHIFT;
            "PACK":   code = PACK;
            "UNPACK": code = UNPACK;
            default:  known = 1'b0;
        endcase
    endtask

    // NOP first (optionally loading Y from a), then hold the operation until done.
    task automatic run_case(input logic [NAME_W-1:0] name, input alu_op_e code,
                            input logic wy_val, input logic [`ALU_WORD_W-1:0] a_val,
                            input logic [`ALU_WORD_W-1:0] b_val,
                            input logic [`ALU_WORD_W-1:0] exp_val);
        int   cycles;
        logic seen;
        drive_nop(wy_val, a_val);
        @(posedge clk);
        #1;
        op        = code;
        wy        = 1'b0;
        a.raw     = a_val;
        b.raw     = b_val;
        exp_acc   = exp_val;
        case_name = name;
        cycles    = 0;
        seen      = 1'b0;
        while (!seen && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
            seen = done;
        end
        if (seen) begin
            cases_done++;
        end else begin
            timeout_count++;
            $display("Case %0s: done never came within %0d cycles", name, DONE_TIMEOUT);
        end
        drive_nop(1'b0, '0);
    endtask

    initial begin
        int                     fd;
        int                     n;
        int                     cycles;
        logic [LINE_W-1:0]      line;
        logic [NAME_W-1:0]      name_txt;
        logic [63:0]            op_txt;
        logic [31:0]            wy_val;
        logic [`ALU_WORD_W-1:0] a_val;
        logic [`ALU_WORD_W-1:0] b_val;
        logic [`ALU_WORD_W-1:0] exp_val;
        alu_op_e                code;
        logic                   known;
        drive_nop(1'b0, '0);
        exp_acc       = '0;
        case_name     = '0;
        cases_done    = 0;
        timeout_count = 0;
        other_errors  = 0;
        cycles        = 0;
        while (!rst_n && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        #1;
        if (!rst_n) begin
            $display("Reset was never released");
            other_errors++;
        end
        // Start with a nonzero Y so that an operation that clears Y shows it.
        drive_nop(1'b1, Y_FILL);
        @(posedge clk);
        #1;
        drive_nop(1'b0, '0);
        fd = $fopen("dv/alu_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the cases file dv/alu_cases.txt");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                n = $fgets(line, fd);
                n = $sscanf(line, "%s %s %h %h %h %h",
                            name_txt, op_txt, wy_val, a_val, b_val, exp_val);
                // Comment and blank lines do not yield all six fields.
                if (n == 6) begin
                    op_from_name(op_txt, code, known);
                    if (known) begin
                        run_case(name_txt, code, wy_val[0], a_val, b_val, exp_val);
                    end else begin
                        $display("Case %0s names an unknown operation %0s", name_txt, op_txt);
                        other_errors++;
                    end
                end
            end
            $fclose(fd);
        end
        repeat (3) @(posedge clk);
        #1;
        if (check_count != cases_done) begin
            $display("Checker saw %0d results for %0d finished cases", check_count, cases_done);
            other_errors++;
        end
        if (cases_done == 0) begin
            $display("No case ran to completion");
            other_errors++;
        end
        $display("Cases: %0d, checks: %0d, mismatches: %0d, timeouts: %0d, other errors: %0d",
                 cases_done, check_count, mismatch_count, timeout_count, other_errors);
        if (mismatch_count == 0 && timeout_count == 0 && other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/alu_cases.txt
# name op wy a b expected_acc
# values in hex; wy set loads Y from a during the NOP before the operation
and_basic        AND    0 F0F01234ABCD 0FF0FF005A5A 00F012000A48
yta_after_and    YTA    0 000000000000 000000000000 000000000000
or_basic         OR     0 F0F01234ABCD 0FF0FF005A5A FFF0FF34FBDF
xor_basic        XOR    0 F0F01234ABCD 0FF0FF005A5A FF00ED34F197
yta_after_xor    YTA    0 000000000000 000000000000 F0F01234ABCD
yta_preload      YTA    1 0123456789AB 000000000000 0123456789AB
arx_carry        ARX    0 800000000000 800000000005 000000000006
arx_all_ones     ARX    0 FFFFFFFFFFFF FFFFFFFFFFFF FFFFFFFFFFFF
acx_byte         ACX    0 0000000000FF 000000000010 000000000018
acx_wrap         ACX    0 800000000001 FFFFFFFFFFFF 000000000002
anx_top          ANX    0 800000000000 000000000000 000000000001
anx_bottom       ANX    0 000000000001 000000000002 000000000032
anx_zero         ANX    0 000000000000 000000000007 000000000007
anx_wrap         ANX    0 000010000000 FFFFFFFFFFF0 000000000005
shr_0            SHIFT  0 123456789ABC 800000000000 123456789ABC
shr_1            SHIFT  0 123456789ABC 820000000000 091A2B3C4D5E
shr_5            SHIFT  0 123456789ABC 8A0000000000 0091A2B3C4D5
shr_13           SHIFT  0 123456789ABC 9A0000000000 000091A2B3C4
shl_1            SHIFT  0 FEDCBA987654 7E0000000000 FDB97530ECA8
yta_after_shl_1  YTA    0 000000000000 000000000000 000000000001
shl_5            SHIFT  0 FEDCBA987654 760000000000 DB97530ECA80
yta_after_shl_5  YTA    0 000000000000 000000000000 00000000001F
shl_13           SHIFT  0 FEDCBA987654 660000000000 97530ECA8000
yta_after_shl_13 YTA    0 000000000000 000000000000 000000001FDB
pack_low_byte    PACK   0 123456789ABC 0000000000FF BC0000000000
pack_ends        PACK   0 A00000000005 F0000000000F A50000000000
pack_odd         PACK   0 FFFF0000FFFF AAAAAAAAAAAA FF00FF000000
unpack_ends      UNPACK 0 0000000000A5 F0000000000F A00000000005
unpack_odd       UNPACK 0 000000FF00FF AAAAAAAAAAAA AAAA0000AAAA
unpack_full      UNPACK 0 123456789ABC FFFFFFFFFFFF 123456789ABC

//--- list.f
+incdir+src
src/alu_word_pkg.sv
src/alu_op_pkg.sv
src/alu_decode.sv
src/alu_shift_step.sv
src/alu_execute.sv
src/mesm_alu.sv
dv/tb_clock_gen.sv
dv/alu_checker.sv
dv/tb_mesm_alu.sv

//--- run.sh
#!/bin/sh
# Build the simulation with Verilator and run it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mesm_alu -f list.f -o tb_mesm_alu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_mesm_alu > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
exit 0
